// File: compile.f
+incdir+sim
src/backend_pkg.sv
src/rename_unit.sv
src/reorder_buffer.sv
src/reg_file.sv
src/alu_unit.sv
src/branch_unit.sv
src/backend.sv
sim/tb_backend.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_backend -f compile.f

out=$(./obj_dir/Vtb_backend 2>&1 || true)
printf '%s\n' "$out"

# status comes from the search for the pass line
printf '%s\n' "$out" | grep -q "All checks passed"

// File: sim/backend_model.svh
`ifndef BACKEND_MODEL_SVH
`define BACKEND_MODEL_SVH

logic [15:0] lfsr_state;
word_t       arch_regs [num_arch_regs];  // in-order architectural state
commit_t     exp_q [$];                  // expected commits, oldest first

task automatic reset_model(logic [15:0] seed);
    lfsr_state = seed;
    for (int i = 0; i < num_arch_regs; i++) begin
        arch_regs[i] = '0;
    end
    exp_q.delete();
endtask

// galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// one step per bit taken
function automatic logic [31:0] random_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

function automatic uop_t make_op(int index, word_t pc);
    uop_t op;
    logic few_dests;
    few_dests = (index >= 100) && (index < 200);  // hammer regs 0..3 to recycle tags
    op       = '0;
    op.valid = 1'b1;
    op.pc    = pc;
    op.src1  = arch_idx_t'(random_bits(4));
    op.src2  = arch_idx_t'(random_bits(4));
    if (random_bits(8) < 52) begin  // roughly one in five
        op.unit                   = unit_bru;
        op.data.bru.predict_taken = 1'(random_bits(1));
        op.data.bru.cond          = bru_cond_e'(random_bits(2));
        op.data.bru.offset        = 18'(random_bits(18));
    end else begin
        op.unit                = unit_alu;
        op.alu_op              = alu_op_e'(random_bits(3) % 6);
        op.dest                = few_dests ? arch_idx_t'(random_bits(2))
                                           : arch_idx_t'(random_bits(4));
        op.data.alu.use_imm    = 1'(random_bits(1));
        op.data.alu.imm        = 16'(random_bits(16));
    end
    return op;
endfunction

// executes one op on the architectural array and returns its commit record
function automatic commit_t model_execute(uop_t op);
    commit_t                        c;
    word_t                          a;
    word_t                          b;
    word_t                          r;
    logic                           t;
    logic signed [offset_width-1:0] off;
    c    = '0;
    c.pc = op.pc;
    a    = arch_regs[op.src1];
    if (op.unit == unit_alu) begin
        b = op.data.alu.use_imm ? {{16{op.data.alu.imm[15]}}, op.data.alu.imm}
                                : arch_regs[op.src2];
        case (op.alu_op)
            alu_add: r = a + b;
            alu_sub: r = a - b;
            alu_and: r = a & b;
            alu_or:  r = a | b;
            alu_xor: r = a ^ b;
            default: r = a << b[4:0];
        endcase
        arch_regs[op.dest] = r;
        c.arch_dest = op.dest;
        c.has_dest  = 1'b1;
        c.value     = r;
    end else begin
        b = arch_regs[op.src2];
        case (op.data.bru.cond)
            cond_eq: t = (a == b);
            cond_ne: t = (a != b);
            cond_lt: t = ($signed(a) < $signed(b));
            default: t = ($signed(a) >= $signed(b));
        endcase
        off                 = op.data.bru.offset;  // sign extends
        c.is_branch         = 1'b1;
        c.taken             = t;
        c.mispredict        = t ^ op.data.bru.predict_taken;
        c.correction_offset = t ? off : offset_width'(4);
    end
    return c;
endfunction

`endif

// File: sim/tb_backend.sv
`default_nettype none
`timescale 1ns/1ps

module tb_backend;
    import backend_pkg::*;

    localparam int num_ops        = 300;
    localparam int reset_cycles   = 8;
    localparam int drive_delay    = 10;
    localparam int timeout_cycles = reset_cycles + num_ops * 20;

    logic         clk_in;
    logic         rst_n;
    uop_t         insn;
    logic         ready;
    logic         commit_valid;
    commit_t      commit;
    bru_resolve_t bru_resolve;
    int           accepted_count;
    int           commit_count;

    `include "backend_model.svh"

    backend u_backend (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .insn         (insn),
        .ready        (ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .bru_resolve  (bru_resolve)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        abort_run();
    endtask

    task automatic report_failure(string what);
        $display("at %0t ns: %s", $time, what);
        abort_run();
    endtask

    task automatic check_field(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    // outputs settle between edges, so everything is sampled on the falling edge
    always @(negedge clk_in) begin : commit_monitor
        commit_t exp;
        if (rst_n && commit_valid) begin
            assert (exp_q.size() > 0) else report_failure("commit with no accepted op pending");
            exp = exp_q.pop_front();
            check_field("commit.is_branch", 32'(commit.is_branch), 32'(exp.is_branch));
            check_field("commit.has_dest", 32'(commit.has_dest), 32'(exp.has_dest));
            check_field("commit.pc", commit.pc, exp.pc);
            check_field("commit.value", commit.value, exp.value);
            check_field("commit.taken", 32'(commit.taken), 32'(exp.taken));
            check_field("commit.mispredict", 32'(commit.mispredict), 32'(exp.mispredict));
            check_field("commit.correction_offset", 32'(commit.correction_offset),
                        32'(exp.correction_offset));
            if (exp.has_dest) begin
                check_field("commit.arch_dest", 32'(commit.arch_dest), 32'(exp.arch_dest));
            end
            check_field("bru_resolve.resolved", 32'(bru_resolve.resolved), 32'(exp.is_branch));
            if (exp.is_branch) begin  // predictor port mirrors the commit
                check_field("bru_resolve.taken", 32'(bru_resolve.taken), 32'(exp.taken));
                check_field("bru_resolve.pc_incorrect", 32'(bru_resolve.pc_incorrect),
                            32'(exp.mispredict));
                check_field("bru_resolve.pc", bru_resolve.pc, exp.pc);
                check_field("bru_resolve.correction_offset",
                            32'(bru_resolve.correction_offset), 32'(exp.correction_offset));
            end
            commit_count++;
        end else if (rst_n) begin
            check_field("bru_resolve.resolved", 32'(bru_resolve.resolved), 32'(0));
        end
    end

    // worst case of 20 cycles per op plus reset
    initial begin
        repeat (timeout_cycles) @(posedge clk_in);
        report_failure("timeout, not all ops committed in time");
    end

    initial begin
        uop_t op;
        word_t pc;
        logic  accepted;
        insn           = '0;
        rst_n          = 1'b0;
        accepted_count = 0;
        commit_count   = 0;
        pc             = 32'h0000_1000;
        reset_model(16'd24786);
        repeat (reset_cycles) @(posedge clk_in);
        #drive_delay;
        rst_n = 1'b1;

        // idle after reset
        repeat (3) begin
            @(negedge clk_in);
            check_field("ready", 32'(ready), 32'(1));
            check_field("commit_valid", 32'(commit_valid), 32'(0));
            @(posedge clk_in);
            #drive_delay;
        end

        for (int n = 0; n < num_ops; n++) begin
            op   = make_op(n, pc);
            pc   = pc + 4;
            insn = op;
            accepted = 1'b0;
            while (!accepted) begin  // insn held while ready is low
                @(negedge clk_in);
                accepted = ready;
                @(posedge clk_in);
                if (accepted) begin
                    exp_q.push_back(model_execute(op));
                    accepted_count++;
                end
                #drive_delay;
            end
        end
        insn = '0;

        while (commit_count < accepted_count) begin
            @(posedge clk_in);
        end
        repeat (10) @(posedge clk_in);  // room for stray commits to show up

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/alu_unit.sv
`default_nettype none
`timescale 1ns/1ps

module alu_unit (
    input  logic                    clk_in,
    input  logic                    rst_n,
    input  backend_pkg::issue_pkt_t issue,
    output backend_pkg::writeback_t wb
);
    import backend_pkg::*;

    alu_fields_t f;
    word_t       op_a;
    word_t       op_b;
    word_t       result;

    assign f    = issue.uop.data.alu;
    assign op_a = issue.src1_val;
    assign op_b = f.use_imm ? {{(word_size-16){f.imm[15]}}, f.imm} : issue.src2_val;

    always_comb begin
        case (issue.uop.alu_op)
            alu_add: result = op_a + op_b;
            alu_sub: result = op_a - op_b;
            alu_and: result = op_a & op_b;
            alu_or:  result = op_a | op_b;
            alu_xor: result = op_a ^ op_b;
            alu_sll: result = op_a << op_b[4:0];   // low five bits only
            default: result = '0;
        endcase
    end

    // one cycle of latency, valid is the only reset flop
    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= issue.valid;
        end
        wb.rob_ptr    <= issue.rob_ptr;
        wb.phys_dest  <= issue.phys_dest;
        wb.has_dest   <= 1'b1;
        wb.result     <= result;
        wb.taken      <= 1'b0;
        wb.mispredict <= 1'b0;
    end

endmodule

`default_nettype wire

// File: src/backend.sv
`default_nettype none
`timescale 1ns/1ps

module backend (
    input  logic                      clk_in,
    input  logic                      rst_n,
    input  backend_pkg::uop_t         insn,
    output logic                      ready,
    output logic                      commit_valid,
    output backend_pkg::commit_t      commit,
    output backend_pkg::bru_resolve_t bru_resolve
);
    import backend_pkg::*;

    renamed_uop_t             renamed;
    renamed_uop_t             alu_issue_uop;
    renamed_uop_t             bru_issue_uop;
    logic                     accept;
    logic                     can_rename;
    logic                     has_space;
    logic                     free_valid;
    phys_idx_t                free_reg;
    logic [num_phys_regs-1:0] scoreboard;
    rob_ptr_t                 alu_issue_ptr;
    rob_ptr_t                 bru_issue_ptr;
    logic                     alu_issue_valid;
    logic                     bru_issue_valid;
    phys_idx_t                read_idx [read_ports];
    word_t                    read_data [read_ports];
    issue_pkt_t               alu_pkt;
    issue_pkt_t               bru_pkt;
    writeback_t               alu_wb;
    writeback_t               bru_wb;

    assign ready  = has_space && can_rename;
    assign accept = insn.valid && ready;

    assign read_idx[0] = alu_issue_uop.phys_src1;
    assign read_idx[1] = alu_issue_uop.phys_src2;
    assign read_idx[2] = bru_issue_uop.phys_src1;
    assign read_idx[3] = bru_issue_uop.phys_src2;

    // selected entry plus its operands, one packet per unit
    assign alu_pkt = '{valid: alu_issue_valid, rob_ptr: alu_issue_ptr,
                       uop: alu_issue_uop.uop, phys_dest: alu_issue_uop.phys_dest,
                       src1_val: read_data[0], src2_val: read_data[1]};
    assign bru_pkt = '{valid: bru_issue_valid, rob_ptr: bru_issue_ptr,
                       uop: bru_issue_uop.uop, phys_dest: bru_issue_uop.phys_dest,
                       src1_val: read_data[2], src2_val: read_data[3]};

    rename_unit u_rename (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .insn       (insn),
        .accept     (accept),
        .free_valid (free_valid),
        .free_reg   (free_reg),
        .renamed    (renamed),
        .can_rename (can_rename)
    );

    reorder_buffer u_rob (
        .clk_in          (clk_in),
        .rst_n           (rst_n),
        .renamed         (renamed),
        .accept          (accept),
        .scoreboard      (scoreboard),
        .alu_wb          (alu_wb),
        .bru_wb          (bru_wb),
        .alu_issue_ptr   (alu_issue_ptr),
        .bru_issue_ptr   (bru_issue_ptr),
        .alu_issue_valid (alu_issue_valid),
        .bru_issue_valid (bru_issue_valid),
        .alu_issue_uop   (alu_issue_uop),
        .bru_issue_uop   (bru_issue_uop),
        .has_space       (has_space),
        .commit_valid    (commit_valid),
        .commit          (commit),
        .free_valid      (free_valid),
        .free_reg        (free_reg),
        .bru_resolve     (bru_resolve)
    );

    reg_file u_reg_file (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .read_idx    (read_idx),
        .read_data   (read_data),
        .alloc_valid (accept && renamed.has_dest),  // new dest goes pending
        .alloc_reg   (renamed.phys_dest),
        .alu_wb      (alu_wb),
        .bru_wb      (bru_wb),
        .scoreboard  (scoreboard)
    );

    alu_unit u_alu (
        .clk_in (clk_in),
        .rst_n  (rst_n),
        .issue  (alu_pkt),
        .wb     (alu_wb)
    );

    branch_unit u_bru (
        .clk_in (clk_in),
        .rst_n  (rst_n),
        .issue  (bru_pkt),
        .wb     (bru_wb)
    );

endmodule

`default_nettype wire

// File: src/backend_pkg.sv
`default_nettype none

package backend_pkg;

    localparam int word_size       = 32;
    localparam int num_arch_regs   = 16;
    localparam int num_phys_regs   = 32;
    localparam int rob_entries     = 8;
    localparam int offset_width    = 19;
    localparam int free_list_depth = num_phys_regs - num_arch_regs;
    localparam int read_ports      = 4;   // alu src1/src2, bru src1/src2

    typedef logic [word_size-1:0]                 word_t;
    typedef logic [$clog2(num_arch_regs)-1:0]     arch_idx_t;
    typedef logic [$clog2(num_phys_regs)-1:0]     phys_idx_t;
    typedef logic [$clog2(rob_entries)-1:0]       rob_ptr_t;
    typedef logic [$clog2(rob_entries):0]         rob_cnt_t;
    typedef logic [$clog2(free_list_depth)-1:0]   free_ptr_t;
    typedef logic [$clog2(free_list_depth):0]     free_cnt_t;

    typedef enum logic {
        unit_alu,
        unit_bru
    } unit_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll
    } alu_op_e;

    // signed compare of src1 against src2
    typedef enum logic [1:0] {
        cond_eq,
        cond_ne,
        cond_lt,
        cond_ge
    } bru_cond_e;

    typedef struct packed {
        logic        use_imm;
        logic [15:0] imm;       // sign-extended at the alu
        logic [3:0]  pad;
    } alu_fields_t;

    typedef struct packed {
        logic               predict_taken;
        bru_cond_e          cond;
        logic signed [17:0] offset;
    } bru_fields_t;

    // the same 21 bits, decoded by the unit that gets the op
    typedef union packed {
        alu_fields_t alu;
        bru_fields_t bru;
    } uop_data_u;

    typedef struct packed {
        logic      valid;
        unit_e     unit;
        alu_op_e   alu_op;
        arch_idx_t dest;    // only alu ops write it
        arch_idx_t src1;
        arch_idx_t src2;
        word_t     pc;
        uop_data_u data;
    } uop_t;

    typedef struct packed {
        uop_t      uop;
        phys_idx_t phys_dest;
        phys_idx_t phys_src1;
        phys_idx_t phys_src2;
        phys_idx_t old_phys_dest;  // returned to the free list at commit
        logic      has_dest;
    } renamed_uop_t;

    typedef struct packed {
        logic      valid;
        rob_ptr_t  rob_ptr;
        uop_t      uop;
        phys_idx_t phys_dest;
        word_t     src1_val;
        word_t     src2_val;
    } issue_pkt_t;

    typedef struct packed {
        logic      valid;
        rob_ptr_t  rob_ptr;
        phys_idx_t phys_dest;
        logic      has_dest;
        word_t     result;     // branches carry the correction offset here
        logic      taken;
        logic      mispredict;
    } writeback_t;

    typedef struct packed {
        arch_idx_t               arch_dest;
        logic                    has_dest;
        word_t                   value;
        logic                    is_branch;
        word_t                   pc;
        logic                    taken;
        logic                    mispredict;
        logic [offset_width-1:0] correction_offset;
    } commit_t;

    typedef struct packed {
        logic                    resolved;
        logic                    taken;
        logic                    pc_incorrect;
        word_t                   pc;
        logic [offset_width-1:0] correction_offset;
    } bru_resolve_t;

endpackage

`default_nettype wire

// File: src/branch_unit.sv
`default_nettype none
`timescale 1ns/1ps

module branch_unit (
    input  logic                    clk_in,
    input  logic                    rst_n,
    input  backend_pkg::issue_pkt_t issue,
    output backend_pkg::writeback_t wb
);
    import backend_pkg::*;

    bru_fields_t             f;
    logic                    taken;
    logic [offset_width-1:0] correction;

    assign f = issue.uop.data.bru;

    always_comb begin
        case (f.cond)
            cond_eq: taken = issue.src1_val == issue.src2_val;
            cond_ne: taken = issue.src1_val != issue.src2_val;
            cond_lt: taken = $signed(issue.src1_val) <  $signed(issue.src2_val);
            cond_ge: taken = $signed(issue.src1_val) >= $signed(issue.src2_val);
        endcase
    end

    // not taken falls through to the next op
    assign correction = taken ? {f.offset[17], f.offset} : offset_width'(4);

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= issue.valid;
        end
        wb.rob_ptr    <= issue.rob_ptr;
        wb.phys_dest  <= issue.phys_dest;
        wb.has_dest   <= 1'b0;   // branches write no register
        wb.result     <= {{(word_size-offset_width){correction[offset_width-1]}}, correction};
        wb.taken      <= taken;
        wb.mispredict <= taken != f.predict_taken;
    end

endmodule

`default_nettype wire

// File: src/reg_file.sv
`default_nettype none
`timescale 1ns/1ps

module reg_file (
    input  logic                                  clk_in,
    input  logic                                  rst_n,
    input  backend_pkg::phys_idx_t                read_idx [backend_pkg::read_ports],
    output backend_pkg::word_t                    read_data [backend_pkg::read_ports],
    input  logic                                  alloc_valid,
    input  backend_pkg::phys_idx_t                alloc_reg,
    input  backend_pkg::writeback_t               alu_wb,
    input  backend_pkg::writeback_t               bru_wb,
    output logic [backend_pkg::num_phys_regs-1:0] scoreboard
);
    import backend_pkg::*;

    word_t      regs_q [num_phys_regs];
    writeback_t wb_port [2];

    assign wb_port[0] = alu_wb;
    assign wb_port[1] = bru_wb;

    always_comb begin
        for (int i = 0; i < read_ports; i++) begin
            read_data[i] = regs_q[read_idx[i]];
        end
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            for (int i = 0; i < num_phys_regs; i++) begin
                regs_q[i] <= '0;
            end
            scoreboard <= '1;   // every register holds a value
        end else begin
            if (alloc_valid) scoreboard[alloc_reg] <= 1'b0;  // value now pending
            for (int p = 0; p < 2; p++) begin
                if (wb_port[p].valid && wb_port[p].has_dest) begin
                    regs_q[wb_port[p].phys_dest]     <= wb_port[p].result;
                    scoreboard[wb_port[p].phys_dest] <= 1'b1;
                end
            end
        end
    end

    // a result only lands in a register that rename marked pending
    for (genvar p = 0; p < 2; p++) begin : g_wb_check
        wb_to_pending: assert property (@(posedge clk_in) disable iff (!rst_n)
            wb_port[p].valid && wb_port[p].has_dest |-> !scoreboard[wb_port[p].phys_dest]);
    end

endmodule

`default_nettype wire

// File: src/rename_unit.sv
`default_nettype none
`timescale 1ns/1ps

module rename_unit (
    input  logic                      clk_in,
    input  logic                      rst_n,
    input  backend_pkg::uop_t         insn,
    input  logic                      accept,
    input  logic                      free_valid,
    input  backend_pkg::phys_idx_t    free_reg,
    output backend_pkg::renamed_uop_t renamed,
    output logic                      can_rename
);
    import backend_pkg::*;

    phys_idx_t map_q [num_arch_regs];
    phys_idx_t fifo_q [free_list_depth];   // free physical registers
    free_ptr_t rd_ptr_q;
    free_ptr_t wr_ptr_q;
    free_cnt_t count_q;
    logic      pop;

    // lookups are combinational, the rob sees the op in the same cycle
    always_comb begin
        renamed.uop           = insn;
        renamed.has_dest      = insn.valid && (insn.unit == unit_alu);
        renamed.phys_src1     = map_q[insn.src1];
        renamed.phys_src2     = map_q[insn.src2];
        renamed.old_phys_dest = map_q[insn.dest];
        renamed.phys_dest     = fifo_q[rd_ptr_q];  // head of the free list
    end

    assign pop        = accept && renamed.has_dest;
    assign can_rename = !renamed.has_dest || (count_q != '0);

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            // identity map, the upper half starts out free
            for (int i = 0; i < num_arch_regs; i++) begin
                map_q[i] <= phys_idx_t'(i);
            end
            for (int i = 0; i < free_list_depth; i++) begin
                fifo_q[i] <= phys_idx_t'(num_arch_regs + i);
            end
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= free_cnt_t'(free_list_depth);
        end else begin
            if (pop) begin
                map_q[insn.dest] <= renamed.phys_dest;
                rd_ptr_q         <= rd_ptr_q + 1'b1;
            end
            if (free_valid) begin
                fifo_q[wr_ptr_q] <= free_reg;   // old mapping from commit
                wr_ptr_q         <= wr_ptr_q + 1'b1;
            end
            count_q <= count_q + free_cnt_t'(free_valid) - free_cnt_t'(pop);
        end
    end

    // ready from the top must keep an empty free list from being popped
    pop_not_empty: assert property (@(posedge clk_in) disable iff (!rst_n)
        pop |-> (count_q != '0));

endmodule

`default_nettype wire

// File: src/reorder_buffer.sv
`default_nettype none
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                                  clk_in,
    input  logic                                  rst_n,
    input  backend_pkg::renamed_uop_t             renamed,
    input  logic                                  accept,
    input  logic [backend_pkg::num_phys_regs-1:0] scoreboard,
    input  backend_pkg::writeback_t               alu_wb,
    input  backend_pkg::writeback_t               bru_wb,
    output backend_pkg::rob_ptr_t                 alu_issue_ptr,
    output backend_pkg::rob_ptr_t                 bru_issue_ptr,
    output logic                                  alu_issue_valid,
    output logic                                  bru_issue_valid,
    output backend_pkg::renamed_uop_t             alu_issue_uop,
    output backend_pkg::renamed_uop_t             bru_issue_uop,
    output logic                                  has_space,
    output logic                                  commit_valid,
    output backend_pkg::commit_t                  commit,
    output logic                                  free_valid,
    output backend_pkg::phys_idx_t                free_reg,
    output backend_pkg::bru_resolve_t             bru_resolve
);
    import backend_pkg::*;

    renamed_uop_t           uop_q [rob_entries];
    word_t                  result_q [rob_entries];
    logic [rob_entries-1:0] taken_q;
    logic [rob_entries-1:0] mispredict_q;
    logic [rob_entries-1:0] valid_q;
    logic [rob_entries-1:0] issued_q;
    logic [rob_entries-1:0] done_q;
    rob_ptr_t               head_q;
    rob_ptr_t               tail_q;
    rob_cnt_t               count_q;
    renamed_uop_t           head_uop;

    // src2 is not needed by an alu op using its immediate
    function automatic logic src_ready(renamed_uop_t u);
        logic need_src2;
        need_src2 = (u.uop.unit == unit_bru) || !u.uop.data.alu.use_imm;
        return scoreboard[u.phys_src1] && (!need_src2 || scoreboard[u.phys_src2]);
    endfunction

    // walk from youngest to oldest so the last hit is the oldest ready op
    always_comb begin
        rob_ptr_t idx;
        alu_issue_valid = 1'b0;
        bru_issue_valid = 1'b0;
        alu_issue_ptr   = head_q;
        bru_issue_ptr   = head_q;
        for (int i = rob_entries - 1; i >= 0; i--) begin
            idx = head_q + rob_ptr_t'(i);
            if (valid_q[idx] && !issued_q[idx] && src_ready(uop_q[idx])) begin
                if (uop_q[idx].uop.unit == unit_alu) begin
                    alu_issue_valid = 1'b1;
                    alu_issue_ptr   = idx;
                end else begin
                    bru_issue_valid = 1'b1;
                    bru_issue_ptr   = idx;
                end
            end
        end
    end

    assign alu_issue_uop = uop_q[alu_issue_ptr];
    assign bru_issue_uop = uop_q[bru_issue_ptr];
    assign has_space     = count_q != rob_cnt_t'(rob_entries);

    // in-order retirement from the head
    assign head_uop     = uop_q[head_q];
    assign commit_valid = valid_q[head_q] && done_q[head_q];
    assign free_valid   = commit_valid && head_uop.has_dest;
    assign free_reg     = head_uop.old_phys_dest;

    always_comb begin
        commit.arch_dest  = head_uop.uop.dest;
        commit.has_dest   = head_uop.has_dest;
        commit.value      = head_uop.has_dest ? result_q[head_q] : '0;
        commit.is_branch  = head_uop.uop.unit == unit_bru;
        commit.pc         = head_uop.uop.pc;
        commit.taken      = taken_q[head_q];
        commit.mispredict = mispredict_q[head_q];
        commit.correction_offset = commit.is_branch ? result_q[head_q][offset_width-1:0] : '0;

        bru_resolve.resolved          = commit_valid && commit.is_branch;
        bru_resolve.taken             = commit.taken;
        bru_resolve.pc_incorrect      = commit.mispredict;
        bru_resolve.pc                = commit.pc;
        bru_resolve.correction_offset = commit.correction_offset;
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            valid_q  <= '0;
            issued_q <= '0;
            done_q   <= '0;
            head_q   <= '0;
            tail_q   <= '0;
            count_q  <= '0;
        end else begin
            if (accept) begin
                valid_q[tail_q]  <= 1'b1;
                issued_q[tail_q] <= 1'b0;
                done_q[tail_q]   <= 1'b0;
                tail_q           <= tail_q + 1'b1;
            end
            if (alu_issue_valid) issued_q[alu_issue_ptr] <= 1'b1;
            if (bru_issue_valid) issued_q[bru_issue_ptr] <= 1'b1;
            if (alu_wb.valid) done_q[alu_wb.rob_ptr] <= 1'b1;
            if (bru_wb.valid) done_q[bru_wb.rob_ptr] <= 1'b1;
            if (commit_valid) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
            count_q <= count_q + rob_cnt_t'(accept) - rob_cnt_t'(commit_valid);
        end
    end

    // entry payload and results
    always_ff @(posedge clk_in) begin
        if (accept) uop_q[tail_q] <= renamed;
        if (alu_wb.valid) begin
            result_q[alu_wb.rob_ptr]     <= alu_wb.result;
            taken_q[alu_wb.rob_ptr]      <= alu_wb.taken;
            mispredict_q[alu_wb.rob_ptr] <= alu_wb.mispredict;
        end
        if (bru_wb.valid) begin
            result_q[bru_wb.rob_ptr]     <= bru_wb.result;
            taken_q[bru_wb.rob_ptr]      <= bru_wb.taken;
            mispredict_q[bru_wb.rob_ptr] <= bru_wb.mispredict;
        end
    end

    // units answer only for entries that were sent to them and are still open
    alu_wb_issued: assert property (@(posedge clk_in) disable iff (!rst_n)
        alu_wb.valid |-> valid_q[alu_wb.rob_ptr] && issued_q[alu_wb.rob_ptr]
            && !done_q[alu_wb.rob_ptr]);
    bru_wb_issued: assert property (@(posedge clk_in) disable iff (!rst_n)
        bru_wb.valid |-> valid_q[bru_wb.rob_ptr] && issued_q[bru_wb.rob_ptr]
            && !done_q[bru_wb.rob_ptr]);

endmodule

`default_nettype wire
